//--- cpu.f
+incdir+.
cpu_pkg.sv
cpu_decode.sv
cpu_execute.sv
cpu_writeback.sv
cpu_core.sv
cpu_checker.sv
tb_cpu.sv

//--- cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_instr_valid,
	input  logic o_retire_valid,
	input  logic o_retire_write,
	input  logic o_fault
);

	// Failure counts per property
	int timing_failures = 0;
	int reset_failures = 0;
	int fault_failures = 0;

	// Decode, execute and retire registers
	retire_timing: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_retire_valid == $past(i_instr_valid, 3))
	else begin
		$error("retire valid does not follow instruction valid by three cycles");
		timing_failures++;
	end

	reset_quiet: assert property (@(posedge i_clock)
		!i_rst_n |-> (!o_retire_valid && !o_fault))
	else begin
		$error("retire valid or fault high during reset");
		reset_failures++;
	end

	fault_no_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_fault |-> (o_retire_valid && !o_retire_write))
	else begin
		$error("fault without retire valid or with write flag set");
		fault_failures++;
	end

endmodule

bind cpu_core cpu_checker u_checker (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_instr_valid(i_instr_valid),
	.o_retire_valid(o_retire_valid),
	.o_retire_write(o_retire_write),
	.o_fault(o_fault)
);

//--- cpu_core.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_core (
	input  logic                    i_clock,
	input  logic                    i_rst_n,

	// Instruction input
	input  logic                    i_instr_valid,
	input  logic [`XLEN-1:0]        i_instr,

	// Retire report
	output logic                    o_retire_valid,
	output logic [`REG_BITS-1:0]    o_retire_rd,
	output logic                    o_retire_write,
	output logic [`XLEN-1:0]        o_retire_value,
	output logic [`TAG_BITS-1:0]    o_retire_tag,
	output logic                    o_fault
);

	cpu_pkg::instr_t instr_word;
	logic [`REG_BITS-1:0] rs1_index;
	logic [`REG_BITS-1:0] rs2_index;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	cpu_pkg::decode_data_t decode_data;
	cpu_pkg::execute_data_t execute_data;
	cpu_pkg::retire_data_t retire_data;

	assign instr_word = i_instr;

	//==========================================================================
	// Decode

	cpu_decode decode (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_instr_valid(i_instr_valid),
		.i_instr(instr_word),
		.o_rs1_index(rs1_index),
		.o_rs2_index(rs2_index),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_data(decode_data)
	);

	//==========================================================================
	// Execute

	cpu_execute execute (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_data(decode_data),
		.i_retire(retire_data),
		.o_data(execute_data)
	);

	//==========================================================================
	// Writeback

	cpu_writeback writeback (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_data(execute_data),
		.i_rs1_index(rs1_index),
		.i_rs2_index(rs2_index),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.o_data(retire_data)
	);

	// Retire record out to ports
	assign o_retire_valid = retire_data.valid;
	assign o_retire_rd = retire_data.rd;
	assign o_retire_write = retire_data.write;
	assign o_retire_value = retire_data.result;
	assign o_retire_tag = retire_data.tag;
	assign o_fault = retire_data.valid & retire_data.fault;

endmodule

//--- cpu_decode.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_decode (
	input  logic                    i_clock,
	input  logic                    i_rst_n,

	input  logic                    i_instr_valid,
	input  cpu_pkg::instr_t         i_instr,

	// Register file read
	output logic [`REG_BITS-1:0]    o_rs1_index,
	output logic [`REG_BITS-1:0]    o_rs2_index,
	input  logic [`XLEN-1:0]        i_rs1_data,
	input  logic [`XLEN-1:0]        i_rs2_data,

	output cpu_pkg::decode_data_t   o_data
);

	logic [`TAG_BITS-1:0] tag_count;
	cpu_pkg::alu_op_t op;
	logic legal;
	logic use_rs2;
	logic [`XLEN-1:0] imm;

	// Operation for funct3 with the base funct7
	function automatic cpu_pkg::alu_op_t base_op(input logic [2:0] funct3);
		case (funct3)
			`F3_ADD:  return cpu_pkg::ALU_ADD;
			`F3_SLL:  return cpu_pkg::ALU_SLL;
			`F3_SLT:  return cpu_pkg::ALU_SLT;
			`F3_SLTU: return cpu_pkg::ALU_SLTU;
			`F3_XOR:  return cpu_pkg::ALU_XOR;
			`F3_SR:   return cpu_pkg::ALU_SRL;
			`F3_OR:   return cpu_pkg::ALU_OR;
			default:  return cpu_pkg::ALU_AND;
		endcase
	endfunction

	assign o_rs1_index = i_instr.r.rs1;
	assign o_rs2_index = i_instr.r.rs2;

	//==========================================================================
	// Instruction decode

	always_comb begin
		op = base_op(i_instr.r.funct3);
		legal = 1'b0;
		use_rs2 = 1'b0;
		imm = {{(`XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
		case (i_instr.r.opcode)
			`OP_REG: begin
				use_rs2 = 1'b1;
				if (i_instr.r.funct7 == `F7_BASE) begin
					legal = 1'b1;
				end else if (i_instr.r.funct7 == `F7_ALT) begin
					// Only ADD and SRL have an alternate form
					if (i_instr.r.funct3 == `F3_ADD) begin
						op = cpu_pkg::ALU_SUB;
						legal = 1'b1;
					end else if (i_instr.r.funct3 == `F3_SR) begin
						op = cpu_pkg::ALU_SRA;
						legal = 1'b1;
					end
				end
			end
			`OP_IMM: begin
				// Shift amount sits where funct7 would be in the upper bits
				if (i_instr.r.funct3 == `F3_SLL) begin
					legal = (i_instr.r.funct7 == `F7_BASE);
				end else if (i_instr.r.funct3 == `F3_SR) begin
					if (i_instr.r.funct7 == `F7_ALT)
						op = cpu_pkg::ALU_SRA;
					legal = (i_instr.r.funct7 == `F7_BASE) || (i_instr.r.funct7 == `F7_ALT);
				end else begin
					legal = 1'b1;
				end
			end
			`OP_LUI: begin
				op = cpu_pkg::ALU_PASS_B;
				legal = 1'b1;
				imm = {i_instr.i.imm, i_instr.i.rs1, i_instr.i.funct3, 12'b0};
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	//==========================================================================
	// Decode record and tag counter

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data <= '0;
			tag_count <= '0;
		end else begin
			o_data.valid <= i_instr_valid;
			o_data.fault <= i_instr_valid & ~legal;
			o_data.tag <= tag_count;
			o_data.rs1 <= i_instr.r.rs1;
			o_data.rs2 <= i_instr.r.rs2;
			o_data.use_rs2 <= use_rs2;
			o_data.rd <= i_instr.r.rd;
			o_data.write <= i_instr_valid & legal;
			o_data.op <= op;
			o_data.a <= i_rs1_data;
			o_data.b <= use_rs2 ? i_rs2_data : imm;
			if (i_instr_valid)
				tag_count <= tag_count + 1'b1;
		end
	end

endmodule

//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and register file
`define XLEN        32
`define REG_COUNT   32
`define REG_BITS    5

// Debug tag counter
`define TAG_BITS    8

//==========================================================================
// Opcodes

`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111

//==========================================================================
// Function codes

`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// Selects SUB and SRA
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

//--- cpu_execute.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_execute (
	input  logic                    i_clock,
	input  logic                    i_rst_n,

	input  cpu_pkg::decode_data_t   i_data,
	input  cpu_pkg::retire_data_t   i_retire,

	output cpu_pkg::execute_data_t  o_data
);

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [4:0] shamt;
	logic [`XLEN-1:0] result;

	// True when a later stage will write this source register
	function automatic logic hits(
		input cpu_pkg::execute_data_t entry,
		input logic [`REG_BITS-1:0] index
	);
		return entry.valid && !entry.fault && entry.write &&
			(entry.rd != '0) && (entry.rd == index);
	endfunction

	function automatic logic [`XLEN-1:0] forward(
		input logic [`REG_BITS-1:0] index,
		input logic [`XLEN-1:0] captured,
		input cpu_pkg::execute_data_t ex_entry,
		input cpu_pkg::retire_data_t rt_entry
	);
		// Newest result first
		if (hits(ex_entry, index))
			return ex_entry.result;
		else if (hits(rt_entry, index))
			return rt_entry.result;
		else
			return captured;
	endfunction

	//==========================================================================
	// Forwarding

	always_comb begin
		op_a = forward(i_data.rs1, i_data.a, o_data, i_retire);
		if (i_data.use_rs2)
			op_b = forward(i_data.rs2, i_data.b, o_data, i_retire);
		else
			op_b = i_data.b;
	end

	assign shamt = op_b[4:0];

	//==========================================================================
	// ALU

	always_comb begin
		case (i_data.op)
			cpu_pkg::ALU_ADD:    result = op_a + op_b;
			cpu_pkg::ALU_SUB:    result = op_a - op_b;
			cpu_pkg::ALU_SLL:    result = op_a << shamt;
			cpu_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			cpu_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, op_a < op_b};
			cpu_pkg::ALU_XOR:    result = op_a ^ op_b;
			cpu_pkg::ALU_SRL:    result = op_a >> shamt;
			cpu_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
			cpu_pkg::ALU_OR:     result = op_a | op_b;
			cpu_pkg::ALU_AND:    result = op_a & op_b;
			cpu_pkg::ALU_PASS_B: result = op_b;
			default:             result = '0;
		endcase
	end

	//==========================================================================
	// Execute record

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data <= '0;
		end else begin
			o_data.valid <= i_data.valid;
			o_data.fault <= i_data.fault;
			o_data.tag <= i_data.tag;
			o_data.rd <= i_data.rd;
			o_data.write <= i_data.write;
			o_data.result <= result;
		end
	end

endmodule

//--- cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

	//==========================================================================
	// Instruction word

	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_BITS-1:0] rs2;
		logic [`REG_BITS-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_BITS-1:0] rd;
		logic [6:0] opcode;
	} r_format_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [`REG_BITS-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_BITS-1:0] rd;
		logic [6:0] opcode;
	} i_format_t;

	// Same word seen as R or I format
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_t;

	//==========================================================================
	// Stage records

	typedef struct packed {
		logic valid;
		logic fault;
		logic [`TAG_BITS-1:0] tag;
		logic [`REG_BITS-1:0] rs1;
		logic [`REG_BITS-1:0] rs2;
		logic use_rs2;
		logic [`REG_BITS-1:0] rd;
		logic write;
		alu_op_t op;
		logic [`XLEN-1:0] a;
		// Immediate when use_rs2 is clear
		logic [`XLEN-1:0] b;
	} decode_data_t;

	typedef struct packed {
		logic valid;
		logic fault;
		logic [`TAG_BITS-1:0] tag;
		logic [`REG_BITS-1:0] rd;
		logic write;
		logic [`XLEN-1:0] result;
	} execute_data_t;

	// Retired instruction, same layout as execute
	typedef execute_data_t retire_data_t;

endpackage

//--- cpu_writeback.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_writeback (
	input  logic                    i_clock,
	input  logic                    i_rst_n,

	input  cpu_pkg::execute_data_t  i_data,

	// Asynchronous read ports for decode
	input  logic [`REG_BITS-1:0]    i_rs1_index,
	input  logic [`REG_BITS-1:0]    i_rs2_index,
	output logic [`XLEN-1:0]        o_rs1_data,
	output logic [`XLEN-1:0]        o_rs2_data,

	output cpu_pkg::retire_data_t   o_data
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`REG_COUNT-1];
	logic write_en;

	assign write_en = i_data.valid && !i_data.fault && i_data.write && (i_data.rd != '0);

	//==========================================================================
	// Register file

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[i_data.rd] <= i_data.result;
		end
	end

	always_comb begin
		if (i_rs1_index == '0)
			o_rs1_data = '0;
		else
			o_rs1_data = regs[i_rs1_index];

		if (i_rs2_index == '0)
			o_rs2_data = '0;
		else
			o_rs2_data = regs[i_rs2_index];
	end

	//==========================================================================
	// Retire record

	// Loaded on the same edge as the register write
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data <= '0;
		end else begin
			o_data.valid <= i_data.valid;
			o_data.fault <= i_data.fault;
			o_data.tag <= i_data.tag;
			o_data.rd <= i_data.rd;
			o_data.write <= i_data.write;
			o_data.result <= i_data.result;
		end
	end

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_cpu;

	typedef logic [`REG_COUNT-1:0][`XLEN-1:0] reg_file_t;

	// Expected retire record
	typedef struct packed {
		logic fault;
		logic write;
		logic [`REG_BITS-1:0] rd;
		logic [`XLEN-1:0] value;
		logic [`TAG_BITS-1:0] tag;
	} expect_t;

	logic i_clock;
	logic i_rst_n;
	logic i_instr_valid;
	logic [`XLEN-1:0] i_instr;
	logic o_retire_valid;
	logic [`REG_BITS-1:0] o_retire_rd;
	logic o_retire_write;
	logic [`XLEN-1:0] o_retire_value;
	logic [`TAG_BITS-1:0] o_retire_tag;
	logic o_fault;

	reg_file_t shadow;
	expect_t expected_q[$];
	logic [`TAG_BITS-1:0] next_tag;
	integer seed;

	cpu_core i_dut (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_instr_valid(i_instr_valid),
		.i_instr(i_instr),
		.o_retire_valid(o_retire_valid),
		.o_retire_rd(o_retire_rd),
		.o_retire_write(o_retire_write),
		.o_retire_value(o_retire_value),
		.o_retire_tag(o_retire_tag),
		.o_fault(o_fault)
	);

	always #10 i_clock = ~i_clock;

	//==========================================================================
	// Instruction encoding

	function automatic logic [`XLEN-1:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		cpu_pkg::instr_t w;
		w.r.funct7 = f7;
		w.r.rs2 = rs2;
		w.r.rs1 = rs1;
		w.r.funct3 = f3;
		w.r.rd = rd;
		w.r.opcode = `OP_REG;
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		cpu_pkg::instr_t w;
		w.i.imm = imm;
		w.i.rs1 = rs1;
		w.i.funct3 = f3;
		w.i.rd = rd;
		w.i.opcode = `OP_IMM;
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, `OP_LUI};
	endfunction

	//==========================================================================
	// Reference model

	// RV32I arithmetic, alt selects SUB or SRA
	function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic [4:0] sh;
		logic [`XLEN-1:0] fill;
		logic less;
		sh = b[4:0];
		fill = a[31] ? ~({`XLEN{1'b1}} >> sh) : '0;
		// Signed order differs from unsigned only when the signs differ
		less = (a[31] != b[31]) ? a[31] : (a < b);
		case (f3)
			`F3_ADD:  return alt ? a - b : a + b;
			`F3_SLL:  return a << sh;
			`F3_SLT:  return {31'b0, less};
			`F3_SLTU: return {31'b0, a < b};
			`F3_XOR:  return a ^ b;
			`F3_SR:   return alt ? ((a >> sh) | fill) : (a >> sh);
			`F3_OR:   return a | b;
			default:  return a & b;
		endcase
	endfunction

	function automatic expect_t model(input logic [`XLEN-1:0] word, input reg_file_t regs);
		cpu_pkg::instr_t ins;
		expect_t e;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] imm;
		logic alt;
		logic legal;
		ins = word;
		e = '0;
		legal = 1'b0;
		e.rd = ins.r.rd;
		a = regs[ins.r.rs1];
		imm = {{(`XLEN-12){ins.i.imm[11]}}, ins.i.imm};
		case (ins.r.opcode)
			`OP_LUI: begin
				legal = 1'b1;
				e.value = {word[31:12], 12'b0};
			end
			`OP_REG: begin
				alt = (ins.r.funct7 == `F7_ALT);
				legal = (ins.r.funct7 == `F7_BASE) ||
					(alt && (ins.r.funct3 == `F3_ADD || ins.r.funct3 == `F3_SR));
				if (legal)
					e.value = alu_ref(ins.r.funct3, alt, a, regs[ins.r.rs2]);
			end
			`OP_IMM: begin
				alt = (ins.i.funct3 == `F3_SR) && (ins.r.funct7 == `F7_ALT);
				// Shift immediates carry funct7 in their upper bits
				if (ins.i.funct3 == `F3_SLL || ins.i.funct3 == `F3_SR)
					legal = (ins.r.funct7 == `F7_BASE) || alt;
				else
					legal = 1'b1;
				if (legal)
					e.value = alu_ref(ins.i.funct3, alt, a, imm);
			end
			default: ;
		endcase
		e.fault = ~legal;
		e.write = legal;
		return e;
	endfunction

	//==========================================================================
	// Stimulus and checking

	task automatic issue(input logic [`XLEN-1:0] word);
		expect_t e;
		e = model(word, shadow);
		e.tag = next_tag;
		next_tag = next_tag + 1'b1;
		if (e.write && e.rd != '0)
			shadow[e.rd] = e.value;
		expected_q.push_back(e);
		@(posedge i_clock);
		i_instr_valid <= 1'b1;
		i_instr <= word;
	endtask

	// Junk on the bus must be ignored
	task automatic bubble();
		@(posedge i_clock);
		i_instr_valid <= 1'b0;
		i_instr <= $random(seed);
	endtask

	task automatic check(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] want,
		input string what);
		if (got !== want) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("TEST FAILED");
			$fatal(1, "Stopped on a wrong retire field");
		end
	endtask

	task automatic abort(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		$display("TEST FAILED");
		$fatal(1, "Stopped on a protocol error");
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0) begin
			if (cycles == 20)
				abort("timed out waiting for outstanding instructions to retire");
			else begin
				@(posedge i_clock);
				cycles++;
			end
		end
	endtask

	function automatic logic [`XLEN-1:0] random_word();
		logic [31:0] r;
		logic [2:0] f3;
		logic [6:0] f7;
		r = $random(seed);
		f3 = r[11:9];
		f7 = (r[12] && (f3 == `F3_ADD || f3 == `F3_SR)) ? `F7_ALT : `F7_BASE;
		// Eight registers only, to get plenty of dependencies
		case (r[15:13])
			3'd0, 3'd1, 3'd2:
				return r_word(f7, {2'b0, r[8:6]}, {2'b0, r[5:3]}, f3, {2'b0, r[2:0]});
			3'd3, 3'd4, 3'd5: begin
				if (f3 == `F3_SLL || f3 == `F3_SR)
					return i_word({f7, r[20:16]}, {2'b0, r[5:3]}, f3, {2'b0, r[2:0]});
				return i_word(r[27:16], {2'b0, r[5:3]}, f3, {2'b0, r[2:0]});
			end
			3'd6: return lui_word({2'b0, r[2:0]}, {r[31:16], r[15:12]});
			default: return $random(seed);
		endcase
	endfunction

	always @(negedge i_clock) begin : compare
		expect_t e;
		if (i_rst_n && o_retire_valid) begin
			if (expected_q.size() == 0) begin
				abort("an instruction retired with none outstanding");
			end else begin
				e = expected_q.pop_front();
				check(o_retire_tag, e.tag, "tag");
				check(o_fault, e.fault, "fault");
				check(o_retire_write, e.write, "write flag");
				check(o_retire_rd, e.rd, "rd");
				if (!e.fault)
					check(o_retire_value, e.value, "value");
			end
		end
	end

	// Bound assertions count their failures
	always @(negedge i_clock) begin
		if (i_dut.u_checker.timing_failures + i_dut.u_checker.reset_failures +
			i_dut.u_checker.fault_failures != 0)
			abort("an assertion on the retire outputs failed");
	end

	initial begin
		logic [31:0] gap;
		i_clock = 1'b0;
		i_rst_n = 1'b0;
		i_instr_valid = 1'b0;
		i_instr = '0;
		seed = 32'h89037065;
		next_tag = '0;
		shadow = '0;
		repeat (5) @(posedge i_clock);
		i_rst_n <= 1'b1;

		// Operand setup, LUI and back-to-back use
		issue(lui_word(5'd1, 20'h80000));
		issue(i_word(12'h005, 5'd1, `F3_ADD, 5'd1));
		issue(i_word(12'hffd, 5'd0, `F3_ADD, 5'd2));
		issue(i_word(12'h064, 5'd0, `F3_ADD, 5'd3));
		issue(lui_word(5'd4, 20'h12345));
		issue(i_word(12'h678, 5'd4, `F3_ADD, 5'd4));

		// Register-immediate operations
		issue(i_word(12'hfff, 5'd4, `F3_ADD, 5'd5));
		issue(i_word(12'hffe, 5'd2, `F3_SLT, 5'd6));
		issue(i_word(12'h005, 5'd2, `F3_SLTU, 5'd7));
		issue(i_word(12'hfff, 5'd3, `F3_SLTU, 5'd7));
		issue(i_word(12'h0f0, 5'd4, `F3_XOR, 5'd8));
		issue(i_word(12'h801, 5'd3, `F3_OR, 5'd9));
		issue(i_word(12'h7f0, 5'd4, `F3_AND, 5'd10));
		issue(i_word({`F7_BASE, 5'd4}, 5'd4, `F3_SLL, 5'd8));
		issue(i_word({`F7_BASE, 5'd8}, 5'd1, `F3_SR, 5'd9));
		issue(i_word({`F7_ALT, 5'd8}, 5'd1, `F3_SR, 5'd10));

		// Register-register operations
		issue(r_word(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd11));
		issue(r_word(`F7_ALT, 5'd4, 5'd3, `F3_ADD, 5'd12));
		issue(r_word(`F7_BASE, 5'd3, 5'd4, `F3_SLL, 5'd13));
		issue(r_word(`F7_BASE, 5'd3, 5'd1, `F3_SLT, 5'd14));
		issue(r_word(`F7_BASE, 5'd3, 5'd1, `F3_SLTU, 5'd15));
		issue(r_word(`F7_BASE, 5'd2, 5'd4, `F3_XOR, 5'd16));
		issue(r_word(`F7_BASE, 5'd3, 5'd1, `F3_SR, 5'd17));
		issue(r_word(`F7_ALT, 5'd3, 5'd1, `F3_SR, 5'd18));
		issue(r_word(`F7_BASE, 5'd4, 5'd2, `F3_OR, 5'd19));
		issue(r_word(`F7_BASE, 5'd1, 5'd4, `F3_AND, 5'd19));

		// Dependencies at distance 1, 2 and 3 on both sources
		for (int d = 1; d <= 3; d++) begin
			issue(i_word(12'(7 * d), 5'd3, `F3_ADD, 5'd20));
			for (int k = 1; k < d; k++)
				issue(i_word(12'h001, 5'd0, `F3_ADD, 5'd21));
			issue(r_word(`F7_BASE, 5'd20, 5'd20, `F3_ADD, 5'd22));
			issue(r_word(`F7_ALT, 5'd20, 5'd4, `F3_ADD, 5'd23));
		end
		// Execute entry wins over retire entry
		issue(i_word(12'h001, 5'd0, `F3_ADD, 5'd24));
		issue(i_word(12'h002, 5'd0, `F3_ADD, 5'd24));
		issue(r_word(`F7_BASE, 5'd24, 5'd24, `F3_ADD, 5'd25));

		// x0 as destination
		issue(i_word(12'h005, 5'd3, `F3_ADD, 5'd0));
		issue(r_word(`F7_BASE, 5'd3, 5'd0, `F3_ADD, 5'd26));
		bubble();
		issue(r_word(`F7_BASE, 5'd0, 5'd0, `F3_OR, 5'd26));
		issue(i_word(12'h000, 5'd0, `F3_ADD, 5'd27));

		// Illegal words aimed at x28
		issue(i_word(12'h037, 5'd0, `F3_ADD, 5'd28));
		issue({12'h001, 5'd3, 3'b010, 5'd28, 7'b0000011});
		issue(r_word(7'b0000001, 5'd3, 5'd3, `F3_ADD, 5'd28));
		issue(r_word(`F7_ALT, 5'd3, 5'd3, `F3_XOR, 5'd28));
		issue(i_word({`F7_ALT, 5'd1}, 5'd3, `F3_SLL, 5'd28));
		issue(i_word({7'b0000001, 5'd1}, 5'd3, `F3_SR, 5'd28));
		issue(32'h0000_0000);
		issue(r_word(`F7_BASE, 5'd0, 5'd28, `F3_ADD, 5'd29));

		// Random mix with bubbles
		for (int n = 0; n < 400; n++) begin
			gap = $random(seed);
			if (gap[1:0] == 2'b00)
				bubble();
			else
				issue(random_word());
		end

		bubble();
		drain();
		bubble();
		bubble();
		if (i_dut.u_checker.timing_failures == 0 && i_dut.u_checker.reset_failures == 0 &&
			i_dut.u_checker.fault_failures == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
